/* clause_selector.f */
ucs_pkg.sv
recip_table.sv
clause_buffer.sv
ucs_apb_regs.sv
unsat_clause_selector.sv
clause_selector_top.sv
clause_selector_chk.sv
clause_selector_tb.sv

/* Bender.yml */
package:
  name: clause_selector

sources:
  - ucs_pkg.sv
  - recip_table.sv
  - clause_buffer.sv
  - ucs_apb_regs.sv
  - unsat_clause_selector.sv
  - clause_selector_top.sv
  - target: test
    files:
      - clause_selector_chk.sv
      - clause_selector_tb.sv

/* clause_selector_tb.sv */
// directed testbench for the clause selector, apb setup loads and solver-side picks
`timescale 1ns/10ps
`default_nettype none

module clause_selector_tb;

    localparam int unsigned half_period    = 20;      // 40 ns clock
    localparam int unsigned timeout_cycles = 16;

    logic                                  clk_i = 1'b0;
    logic                                  rst_i;
    logic [ucs_pkg::apb_addr_w-1:0]        paddr_i;
    logic                                  psel_i;
    logic                                  penable_i;
    logic                                  pwrite_i;
    logic [ucs_pkg::apb_data_w-1:0]        pwdata_i;
    logic [ucs_pkg::apb_data_w-1:0]        prdata_o;
    logic                                  pready_o;
    logic                                  request_i;
    logic                                  write_disable_i;
    logic                                  fifo_empty_i;
    ucs_pkg::clause_t                      fifo_clause_i;
    logic [ucs_pkg::rand_word_w-1:0]       random_i;
    ucs_pkg::clause_t                      selected_o;
    logic                                  selected_valid_o;

    ucs_pkg::clause_t model_mem [ucs_pkg::buffer_depth];   // expected buffer contents
    ucs_pkg::count_t  model_count;
    logic [31:0]      lfsr_state = 32'h14dfc288;
    int               checks = 0;
    int               errors = 0;
    int               timeouts = 0;

    always #(half_period) clk_i = ~clk_i;

    clause_selector_top dut_i (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .paddr_i          (paddr_i),
        .psel_i           (psel_i),
        .penable_i        (penable_i),
        .pwrite_i         (pwrite_i),
        .pwdata_i         (pwdata_i),
        .prdata_o         (prdata_o),
        .pready_o         (pready_o),
        .request_i        (request_i),
        .write_disable_i  (write_disable_i),
        .fifo_empty_i     (fifo_empty_i),
        .fifo_clause_i    (fifo_clause_i),
        .random_i         (random_i),
        .selected_o       (selected_o),
        .selected_valid_o (selected_valid_o)
    );

    // fibonacci lfsr, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [63:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[62:0], lfsr_state[0]};   // one step per bit
        end
    endtask

    task automatic check_clause(input string name, input ucs_pkg::clause_t got,
                                input ucs_pkg::clause_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input ucs_pkg::count_t got,
                               input ucs_pkg::count_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    // one apb3 transfer, entered and left on a falling edge
    task automatic apb_access(input logic wr, input logic [ucs_pkg::apb_addr_w-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        waited    = 0;
        paddr_i   = addr;                  // setup phase
        pwrite_i  = wr;
        pwdata_i  = wdata;
        psel_i    = 1'b1;
        penable_i = 1'b0;
        @(negedge clk_i);
        penable_i = 1'b1;                  // access phase
        #(half_period / 2);
        while (pready_o !== 1'b1 && waited < timeout_cycles) begin
            @(negedge clk_i);
            #(half_period / 2);
            waited++;
        end
        if (pready_o !== 1'b1) begin
            errors++;
            timeouts++;
            $display("apb transfer to register %0d timed out waiting for pready", addr);
        end
        rdata = prdata_o;                  // mid low phase, stable
        @(negedge clk_i);
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    task automatic apb_write(input logic [ucs_pkg::apb_addr_w-1:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        apb_access(1'b1, addr, data, unused);
    endtask

    task automatic apb_read(input logic [ucs_pkg::apb_addr_w-1:0] addr, output logic [31:0] data);
        apb_access(1'b0, addr, '0, data);
    endtask

    task automatic expect_count();
        logic [31:0] data;
        apb_read(ucs_pkg::reg_count, data);
        check_count("reg_count", data[ucs_pkg::count_w-1:0], model_count);
    endtask

    // n random clauses appended over apb in setup mode
    task automatic load_clauses(input int n);
        logic [63:0] bits;
        logic [ucs_pkg::clause_w-1:0] raw;
        apb_write(ucs_pkg::reg_ctrl, 32'h1);
        for (int i = 0; i < n; i++) begin
            take_bits(ucs_pkg::clause_w, bits);
            raw = bits[ucs_pkg::clause_w-1:0];
            apb_write(ucs_pkg::reg_load_addr, 32'(model_count));
            apb_write(ucs_pkg::reg_load_data, raw[31:0]);          // low word
            apb_write(ucs_pkg::reg_load_data, 32'(raw[ucs_pkg::clause_w-1:32]));  // stores
            model_mem[model_count] = raw;
            model_count++;
        end
        apb_write(ucs_pkg::reg_ctrl, 32'h0);
        expect_count();
    endtask

    // valid rises after the fourth edge past the request edge, seen on the fifth falling edge
    // fifo offered only for the stage 3 edge
    task automatic wait_valid(input logic replace, input ucs_pkg::clause_t fifo_clause);
        int cycles;
        cycles = 0;
        while (selected_valid_o !== 1'b1 && cycles < timeout_cycles) begin
            @(negedge clk_i);
            cycles++;
            request_i     = 1'b0;
            fifo_empty_i  = !(replace && cycles == 3);
            fifo_clause_i = fifo_clause;
        end
        fifo_empty_i = 1'b1;
        if (selected_valid_o !== 1'b1) begin
            errors++;
            timeouts++;
            $display("selected_valid_o never rose after the request");
        end else if (cycles != 5) begin
            errors++;
            $display("selected_valid_o rose %0d cycles after the request instead of 4",
                     cycles - 1);
        end
    endtask

    // one pick, compared against the model, then the model compacts or replaces
    task automatic pick(input logic replace, input ucs_pkg::clause_t fifo_clause);
        logic [63:0] bits;
        int unsigned m;
        int unsigned nr;
        int unsigned idx;
        ucs_pkg::clause_t exp;
        take_bits(ucs_pkg::rand_word_w, bits);
        m   = model_count;
        nr  = bits[ucs_pkg::rand_offset +: ucs_pkg::rand_w];
        idx = nr % m;
        exp = model_mem[idx];
        request_i = 1'b1;
        random_i  = bits[31:0];
        wait_valid(replace, fifo_clause);
        check_clause("selected_o", selected_o, exp);
        @(negedge clk_i);
        check_bit("selected_valid_o", selected_valid_o, 1'b0);   // single cycle strobe
        if (replace) begin
            model_mem[idx] = fifo_clause;
        end else begin
            model_mem[idx] = model_mem[m-1];   // last clause fills the hole
            model_count--;
        end
        expect_count();
    endtask

    // one cycle of fifo traffic without a request
    task automatic fifo_push(input ucs_pkg::clause_t c, input logic frozen);
        write_disable_i = frozen;
        fifo_empty_i    = 1'b0;
        fifo_clause_i   = c;
        @(negedge clk_i);
        fifo_empty_i    = 1'b1;
        write_disable_i = 1'b0;
        if (!frozen) begin
            model_mem[model_count] = c;        // append at slot count
            model_count++;
        end
        expect_count();
    endtask

    task automatic test_reset_state();
        logic [31:0] data;
        apb_read(ucs_pkg::reg_count, data);
        check_count("reg_count", data[ucs_pkg::count_w-1:0], '0);
        apb_read(ucs_pkg::reg_status, data);
        check_bit("status overflow", data[0], 1'b0);
        check_bit("status div0", data[1], 1'b0);
        repeat (4) begin
            @(negedge clk_i);
            check_bit("selected_valid_o", selected_valid_o, 1'b0);
        end
    endtask

    task automatic test_fifo_traffic();
        logic [63:0] bits;
        take_bits(ucs_pkg::clause_w, bits);
        pick(1'b1, bits[ucs_pkg::clause_w-1:0]);       // replace, count held
        take_bits(ucs_pkg::clause_w, bits);
        fifo_push(bits[ucs_pkg::clause_w-1:0], 1'b0);  // append
        take_bits(ucs_pkg::clause_w, bits);
        fifo_push(bits[ucs_pkg::clause_w-1:0], 1'b1);  // frozen, dropped
        while (model_count > 0) begin
            pick(1'b0, '0);                            // drain confirms contents
        end
    endtask

    task automatic test_div0();
        logic [31:0] data;
        logic [63:0] bits;
        apb_read(ucs_pkg::reg_status, data);
        check_bit("status div0", data[1], 1'b0);       // still clear before the empty pick
        take_bits(ucs_pkg::rand_word_w, bits);
        request_i = 1'b1;                              // buffer is empty here
        random_i  = bits[31:0];
        wait_valid(1'b0, '0);
        @(negedge clk_i);
        apb_read(ucs_pkg::reg_status, data);
        check_bit("status div0", data[1], 1'b1);
        apb_write(ucs_pkg::reg_status, 32'h2);         // write one to clear
        apb_read(ucs_pkg::reg_status, data);
        check_bit("status div0", data[1], 1'b0);
        expect_count();
    endtask

    initial begin
        rst_i           = 1'b1;
        paddr_i         = '0;
        psel_i          = 1'b0;
        penable_i       = 1'b0;
        pwrite_i        = 1'b0;
        pwdata_i        = '0;
        request_i       = 1'b0;
        write_disable_i = 1'b0;
        fifo_empty_i    = 1'b1;
        fifo_clause_i   = '0;
        random_i        = '0;
        model_count     = '0;
        repeat (5) @(negedge clk_i);
        rst_i = 1'b0;
        test_reset_state();
        load_clauses(1);
        pick(1'b0, '0);                                // single clause, slot 0
        load_clauses(40);
        while (model_count > 2) begin
            pick(1'b0, '0);
        end
        test_fifo_traffic();
        test_div0();
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* clause_selector_chk.sv */
// assertions on the selector request pipeline, count freeze and reset state
`timescale 1ns/10ps
`default_nettype none

module clause_selector_chk (
    input wire                  clk_i,
    input wire                  rst_i,
    input wire                  setup_i,
    input wire                  request_i,
    input wire                  write_disable_i,
    input wire ucs_pkg::count_t count_i,
    input wire                  selected_valid_i
);

    // strobe rises right after the fourth edge, seen on the fifth sample
    valid_after_request: assert property (@(posedge clk_i) disable iff (rst_i)
        request_i && !setup_i |-> ##5 selected_valid_i)
        else $error("selected_valid_o missing four cycles after request_i");

    valid_only_from_request: assert property (@(posedge clk_i) disable iff (rst_i)
        selected_valid_i |-> $past(request_i && !setup_i, 5))
        else $error("selected_valid_o without a matching request_i");

    // frozen counter while the solver holds the buffer
    count_frozen: assert property (@(posedge clk_i) disable iff (rst_i)
        write_disable_i && !setup_i |=> $stable(count_i))
        else $error("clause count moved under write_disable_i");

    valid_low_after_reset: assert property (@(posedge clk_i)
        rst_i |=> !selected_valid_i)
        else $error("selected_valid_o high after reset");

endmodule

bind unsat_clause_selector clause_selector_chk chk_i (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .setup_i          (setup_i),
    .request_i        (request_i),
    .write_disable_i  (write_disable_i),
    .count_i          (count_q),
    .selected_valid_i (selected_valid_o)
);

`default_nettype wire

/* clause_selector_top.sv */
// clause selector top, apb register block feeding the unsat clause selector
`timescale 1ns/10ps
`default_nettype none

module clause_selector_top (
    input  wire                                  clk_i,
    input  wire                                  rst_i,
    // host apb3
    input  wire [ucs_pkg::apb_addr_w-1:0]        paddr_i,
    input  wire                                  psel_i,
    input  wire                                  penable_i,
    input  wire                                  pwrite_i,
    input  wire [ucs_pkg::apb_data_w-1:0]        pwdata_i,
    output logic [ucs_pkg::apb_data_w-1:0]       prdata_o,
    output logic                                 pready_o,
    // solver port
    input  wire                                  request_i,
    input  wire                                  write_disable_i,
    input  wire                                  fifo_empty_i,
    input  wire ucs_pkg::clause_t                fifo_clause_i,
    input  wire [ucs_pkg::rand_word_w-1:0]       random_i,
    output ucs_pkg::clause_t                     selected_o,
    output logic                                 selected_valid_o
);

    logic               setup;
    logic               load_we;       // pulse, second data beat
    ucs_pkg::buf_addr_t load_addr;
    ucs_pkg::clause_t   load_data;
    logic               clear_div0;    // pulse, w1c on status
    ucs_pkg::count_t    count;
    logic               div0;

    ucs_apb_regs regs_i (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .paddr_i      (paddr_i),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .pwdata_i     (pwdata_i),
        .prdata_o     (prdata_o),
        .pready_o     (pready_o),
        .setup_o      (setup),
        .load_we_o    (load_we),
        .load_addr_o  (load_addr),
        .load_data_o  (load_data),
        .clear_div0_o (clear_div0),
        .count_i      (count),
        .div0_i       (div0)
    );

    unsat_clause_selector selector_i (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .setup_i          (setup),
        .load_we_i        (load_we),
        .load_addr_i      (load_addr),
        .load_data_i      (load_data),
        .clear_div0_i     (clear_div0),
        .request_i        (request_i),
        .write_disable_i  (write_disable_i),
        .fifo_empty_i     (fifo_empty_i),
        .fifo_clause_i    (fifo_clause_i),
        .random_i         (random_i),
        .selected_o       (selected_o),
        .selected_valid_o (selected_valid_o),
        .count_o          (count),
        .div0_o           (div0)
    );

endmodule

`default_nettype wire

/* unsat_clause_selector.sv */
// unsat clause selector, picks NR mod m from the buffer and keeps it compacted
`timescale 1ns/10ps
`default_nettype none

module unsat_clause_selector (
    input  wire                                  clk_i,
    input  wire                                  rst_i,
    // setup loads from the register block
    input  wire                                  setup_i,
    input  wire                                  load_we_i,
    input  wire ucs_pkg::buf_addr_t              load_addr_i,
    input  wire ucs_pkg::clause_t                load_data_i,
    input  wire                                  clear_div0_i,
    // solver side
    input  wire                                  request_i,        // one-cycle pulse
    input  wire                                  write_disable_i,  // freezes buffer and count
    input  wire                                  fifo_empty_i,
    input  wire ucs_pkg::clause_t                fifo_clause_i,
    input  wire [ucs_pkg::rand_word_w-1:0]       random_i,
    output ucs_pkg::clause_t                     selected_o,
    output logic                                 selected_valid_o,
    // status
    output ucs_pkg::count_t                      count_o,
    output logic                                 div0_o
);

    ucs_pkg::count_t                                  count_q;
    logic                                             count_nz;
    logic                                             req_in;
    ucs_pkg::count_t                                  table_addr;
    logic [ucs_pkg::recip_w-1:0]                      recip;

    // selection pipeline
    logic                                             req1, req2, req3, req4;
    logic [ucs_pkg::rand_w-1:0]                       nr1, nr2;
    ucs_pkg::count_t                                  m1, m2;
    logic [ucs_pkg::rand_w+ucs_pkg::recip_w-1:0]      product2;
    logic [ucs_pkg::rand_w-1:0]                       quot2, rem2;
    ucs_pkg::buf_addr_t                               selection3;

    // buffer port a arbitration
    logic                                             pick, append;
    logic                                             en_a, we_a;
    ucs_pkg::buf_addr_t                               addr_a, last_addr;
    ucs_pkg::clause_t                                 din_a, dout_a, last_clause;

    assign count_o   = count_q;
    assign count_nz  = (count_q != '0);
    assign req_in    = request_i & ~setup_i;          // solver ignored during setup
    assign last_addr = count_q[ucs_pkg::buf_addr_w-1:0] - 1'b1;

    // idle with an empty buffer parks on entry 1, so only a real pick trips div0
    assign table_addr = (req_in || count_nz) ? count_q : ucs_pkg::count_t'(1);

    recip_table recip_table_i (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .addr_i       (table_addr),
        .clear_div0_i (clear_div0_i),
        .data_o       (recip),          // 1/m for m1, valid with stage 1
        .div0_o       (div0_o)
    );

    // stage 3 edge actions
    assign pick   = req3 & count_nz & ~setup_i;      // nothing to remove from an empty buffer
    assign append = ~setup_i & ~fifo_empty_i & ~pick;

    always_comb begin
        if (setup_i) begin
            we_a   = load_we_i;
            addr_a = load_addr_i;
            din_a  = load_data_i;
        end else begin
            if (write_disable_i) begin
                we_a = 1'b0;
            end else if (pick) begin
                we_a = ~fifo_empty_i | (selection3 != last_addr);  // last slot just drops
            end else begin
                we_a = append;
            end
            addr_a = pick ? selection3 : count_q[ucs_pkg::buf_addr_w-1:0];
            din_a  = fifo_empty_i ? last_clause : fifo_clause_i;   // compact or replace
        end
    end

    assign en_a = setup_i | req3 | we_a;             // read needed for every stage 3 request

    clause_buffer clause_buffer_i (
        .clk_i    (clk_i),
        .en_a_i   (en_a),
        .we_a_i   (we_a),
        .addr_a_i (addr_a),
        .din_a_i  (din_a),
        .dout_a_o (dout_a),
        .addr_b_i (last_addr),
        .dout_b_o (last_clause)
    );

    // clause counter
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            count_q <= '0;
        end else if (setup_i) begin
            if (load_we_i) begin
                count_q <= count_q + 1'b1;
            end
        end else if (!write_disable_i) begin
            if (pick && fifo_empty_i) begin
                count_q <= count_q - 1'b1;   // removed, replace keeps the count
            end else if (append) begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    // request shift, fixed 4 cycle latency
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            req1             <= 1'b0;
            req2             <= 1'b0;
            req3             <= 1'b0;
            req4             <= 1'b0;
            selected_valid_o <= 1'b0;
        end else begin
            req1             <= req_in;
            req2             <= req1;
            req3             <= req2;
            req4             <= req3;
            selected_valid_o <= req4;
        end
    end

    // NR mod m = NR - floor(NR * (1/m)) * m
    assign quot2 = product2[ucs_pkg::recip_w +: ucs_pkg::rand_w];
    assign rem2  = nr2 - quot2 * ucs_pkg::rand_w'(m2);  // exact below m, wraps harmlessly

    always_ff @(posedge clk_i) begin
        nr1        <= random_i[ucs_pkg::rand_offset +: ucs_pkg::rand_w];  // stage 1
        m1         <= count_q;
        nr2        <= nr1;                                                // stage 2
        m2         <= m1;
        product2   <= nr1 * recip;
        selection3 <= (m2 == ucs_pkg::count_t'(1)) ? '0                   // stage 3
                                                   : rem2[ucs_pkg::buf_addr_w-1:0];
        selected_o <= dout_a;                                             // stage 4
    end

endmodule

`default_nettype wire

/* ucs_apb_regs.sv */
// apb3 register block for selector setup, clause loads, count and status readback
`timescale 1ns/10ps
`default_nettype none

module ucs_apb_regs (
    input  wire                                  clk_i,
    input  wire                                  rst_i,
    // apb3, no pslverr
    input  wire [ucs_pkg::apb_addr_w-1:0]        paddr_i,
    input  wire                                  psel_i,
    input  wire                                  penable_i,
    input  wire                                  pwrite_i,
    input  wire [ucs_pkg::apb_data_w-1:0]        pwdata_i,
    output logic [ucs_pkg::apb_data_w-1:0]       prdata_o,
    output logic                                 pready_o,
    // to the selector
    output logic                                 setup_o,
    output logic                                 load_we_o,
    output ucs_pkg::buf_addr_t                   load_addr_o,
    output ucs_pkg::clause_t                     load_data_o,
    output logic                                 clear_div0_o,
    // from the selector
    input  wire ucs_pkg::count_t                 count_i,
    input  wire                                  div0_i
);

    localparam int unsigned hi_w = ucs_pkg::clause_w - ucs_pkg::apb_data_w;  // 4 bit top beat

    logic                              wr_access;
    logic                              hi_beat_q;      // next data write is the top nibble
    logic [ucs_pkg::apb_data_w-1:0]    data_lo_q;

    assign pready_o  = 1'b1;                           // zero wait states
    assign wr_access = psel_i & penable_i & pwrite_i;  // access phase edge

    // control state and the one-cycle pulses
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            setup_o      <= 1'b0;
            hi_beat_q    <= 1'b0;
            load_we_o    <= 1'b0;
            clear_div0_o <= 1'b0;
        end else begin
            load_we_o    <= 1'b0;
            clear_div0_o <= 1'b0;
            if (wr_access) begin
                case (paddr_i)
                    ucs_pkg::reg_ctrl: begin
                        setup_o   <= pwdata_i[0];
                        hi_beat_q <= 1'b0;     // resync the beat pair
                    end
                    ucs_pkg::reg_load_addr: hi_beat_q <= 1'b0;
                    ucs_pkg::reg_load_data: begin
                        hi_beat_q <= ~hi_beat_q;
                        load_we_o <= hi_beat_q & setup_o;  // only the second beat stores
                    end
                    ucs_pkg::reg_status: clear_div0_o <= pwdata_i[1];  // w1c on div0
                    default: ;
                endcase
            end
        end
    end

    // load address and clause assembly
    always_ff @(posedge clk_i) begin
        if (wr_access && paddr_i == ucs_pkg::reg_load_addr) begin
            load_addr_o <= pwdata_i[ucs_pkg::buf_addr_w-1:0];
        end
        if (wr_access && paddr_i == ucs_pkg::reg_load_data) begin
            if (hi_beat_q) begin
                load_data_o <= {pwdata_i[hi_w-1:0], data_lo_q};
            end else begin
                data_lo_q <= pwdata_i;         // held until the top beat
            end
        end
    end

    // read mux, data valid through the access phase
    always_comb begin
        prdata_o = '0;
        if (psel_i && !pwrite_i) begin
            case (paddr_i)
                ucs_pkg::reg_ctrl:      prdata_o[0] = setup_o;
                ucs_pkg::reg_load_addr: prdata_o[ucs_pkg::buf_addr_w-1:0] = load_addr_o;
                ucs_pkg::reg_load_data: prdata_o = data_lo_q;
                ucs_pkg::reg_count:     prdata_o[ucs_pkg::count_w-1:0] = count_i;
                ucs_pkg::reg_status: begin
                    prdata_o[0] = count_i[ucs_pkg::buf_addr_w];  // overflow
                    prdata_o[1] = div0_i;
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* clause_buffer.sv */
// unsat clause buffer ram, port a read/write read-first, port b registered read
`timescale 1ns/10ps
`default_nettype none

module clause_buffer (
    input  wire                       clk_i,
    input  wire                       en_a_i,
    input  wire                       we_a_i,
    input  wire ucs_pkg::buf_addr_t   addr_a_i,
    input  wire ucs_pkg::clause_t     din_a_i,
    output ucs_pkg::clause_t          dout_a_o,
    input  wire ucs_pkg::buf_addr_t   addr_b_i,
    output ucs_pkg::clause_t          dout_b_o
);

    ucs_pkg::clause_t mem [ucs_pkg::buffer_depth];

    // port a, old contents come out while the slot is overwritten
    always_ff @(posedge clk_i) begin
        if (en_a_i) begin
            dout_a_o <= mem[addr_a_i];
            if (we_a_i) begin
                mem[addr_a_i] <= din_a_i;
            end
        end
    end

    // port b always enabled, tracks the last clause
    always_ff @(posedge clk_i) begin
        dout_b_o <= mem[addr_b_i];
    end

endmodule

`default_nettype wire

/* recip_table.sv */
// reciprocal rom of ceil(2^32/m) for the modulo pipeline, flags reads of entry 0
`timescale 1ns/10ps
`default_nettype none

module recip_table (
    input  wire                            clk_i,
    input  wire                            rst_i,
    input  wire ucs_pkg::count_t           addr_i,
    input  wire                            clear_div0_i,
    output logic [ucs_pkg::recip_w-1:0]    data_o,
    output logic                           div0_o
);

    localparam int unsigned depth_c = ucs_pkg::recip_depth;

    logic [ucs_pkg::recip_w-1:0] rom [depth_c];

    // rounded up so floor(NR * r / 2^32) is exact for NR < 2^18, m <= 2048
    function automatic logic [ucs_pkg::recip_w-1:0] recip_entry(input int unsigned m);
        logic [63:0] num;
        num = (64'd1 << ucs_pkg::recip_w) + 64'(m) - 64'd1;
        if (m == 0) begin
            return '0;                                  // no reciprocal, flagged instead
        end
        return ucs_pkg::recip_w'(num / 64'(m));         // m = 1 wraps to 0, handled downstream
    endfunction

    initial begin
        for (int m = 0; m < depth_c; m++) begin
            rom[m] = recip_entry(m);
        end
    end

    always_ff @(posedge clk_i) begin
        data_o <= rom[addr_i];                          // one cycle read
    end

    // sticky, a new read of 0 beats a clear on the same edge
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            div0_o <= 1'b0;
        end else if (addr_i == '0) begin
            div0_o <= 1'b1;
        end else if (clear_div0_i) begin
            div0_o <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* ucs_pkg.sv */
// unsat clause selector shared widths, clause and count types, apb register map
`default_nettype none

package ucs_pkg;

    // buffer geometry
    localparam int unsigned buffer_depth = 2048;                 // clause slots, power of two
    localparam int unsigned buf_addr_w   = $clog2(buffer_depth);
    localparam int unsigned count_w      = buf_addr_w + 1;       // msb is the overflow bit

    // clause layout
    localparam int unsigned nsat       = 3;                      // literals per clause
    localparam int unsigned lit_addr_w = 12;
    localparam int unsigned clause_w   = nsat * lit_addr_w;      // 36 bits

    // random word and the NR field inside it
    localparam int unsigned rand_word_w = 32;
    localparam int unsigned rand_w      = 18;
    localparam int unsigned rand_offset = 10;                    // NR = random[27:10]

    // reciprocal rom, all bits fractional
    localparam int unsigned recip_w     = 32;
    localparam int unsigned recip_depth = 2 ** count_w;          // covers every count value

    // host bus
    localparam int unsigned apb_addr_w = 4;
    localparam int unsigned apb_data_w = 32;

    typedef logic [nsat-1:0][lit_addr_w-1:0] clause_t;          // literal 0 in the low bits
    typedef logic [count_w-1:0]              count_t;
    typedef logic [buf_addr_w-1:0]           buf_addr_t;

    // register map, paddr is a word index here not a byte offset
    localparam logic [apb_addr_w-1:0] reg_ctrl      = 4'h0;      // bit 0 setup mode
    localparam logic [apb_addr_w-1:0] reg_load_addr = 4'h1;      // slot for the next load
    localparam logic [apb_addr_w-1:0] reg_load_data = 4'h2;      // low word, then high nibble
    localparam logic [apb_addr_w-1:0] reg_count     = 4'h3;      // ro, count with overflow
    localparam logic [apb_addr_w-1:0] reg_status    = 4'h4;      // bit 0 ovf, bit 1 div0 (w1c)

endpackage

`default_nettype wire
